//--- all.f
tsc_pkg.sv
alu.sv
register_file.sv
control_unit.sv
cpu_core.sv
unified_memory.sv
tsc_top.sv
tb_tsc.sv

//--- tb_tsc.sv
`default_nettype none

module tb_tsc;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TEST_BUDGET_NS = 3000; // Worst test is a load plus a run.
	localparam int NUM_TESTS      = 6;
	localparam int WATCHDOG_NS    = NUM_TESTS * TEST_BUDGET_NS + 2000; // Plus reset margin.
	localparam int RUN_LIMIT      = 1000; // Cycles from start to halt.
	localparam int STEP_LIMIT     = 500;  // Model instructions per run.

	logic           clk;
	logic           rst_n;
	logic           start;
	tsc_pkg::load_t load;
	logic           load_valid;
	logic           load_ready;
	tsc_pkg::word_t out_data;
	logic           out_valid;
	logic           out_ready;
	logic           halted;

	tsc_pkg::word_t image [tsc_pkg::MEM_DEPTH]; // Program being built.
	bit             used  [tsc_pkg::MEM_DEPTH];
	tsc_pkg::word_t mmem  [tsc_pkg::MEM_DEPTH]; // Model view of DUT memory.
	tsc_pkg::word_t mregs [4];                  // Model registers.
	tsc_pkg::word_t got_q[$];
	tsc_pkg::word_t exp_q[$];
	tsc_pkg::word_t model_q[$];
	tsc_pkg::word_t hand_q[$]; // Fixed constants if a test gives them.
	int emit_at;
	int hold_low;
	bit bp_enable;
	int tests_run;
	int tests_failed;
	int error_count;

	tsc_top tsc_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.load       (load),
		.load_valid (load_valid),
		.load_ready (load_ready),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.halted     (halted)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

	// Output sink with optional random stalls.
	initial begin
		out_ready = 1'b1;
		hold_low  = 0;
		forever begin
			@(posedge clk);
			if (hold_low > 0) begin
				hold_low--;
				out_ready <= 1'b0;
			end else begin
				out_ready <= 1'b1;
				if (bp_enable) hold_low = $urandom_range(1, 6); // Next stall length.
			end
		end
	end

	// Every accepted beat in order.
	initial begin
		forever begin
			@(posedge clk);
			if (out_valid && out_ready) got_q.push_back(out_data);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t ns, run stopped", $time);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic tsc_pkg::word_t rtype_word(int rs, int rt, int rd, tsc_pkg::func_e f);
		return {tsc_pkg::OP_ALU, rs[1:0], rt[1:0], rd[1:0], f};
	endfunction

	function automatic tsc_pkg::word_t imm_word(tsc_pkg::opcode_e op, int rs, int rt, int imm);
		return {op, rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic tsc_pkg::word_t jump_word(tsc_pkg::opcode_e op, int target);
		return {op, target[11:0]};
	endfunction

	// R-type meaning per the ISA.
	function automatic tsc_pkg::word_t func_ref(logic [5:0] f, tsc_pkg::word_t a,
			tsc_pkg::word_t b);
		case (tsc_pkg::func_e'(f))
			tsc_pkg::FUNC_ADD: return a + b;
			tsc_pkg::FUNC_SUB: return a - b;
			tsc_pkg::FUNC_AND: return a & b;
			tsc_pkg::FUNC_ORR: return a | b;
			tsc_pkg::FUNC_NOT: return ~a;
			tsc_pkg::FUNC_TCP: return 16'd0 - a;
			tsc_pkg::FUNC_SHL: return {a[14:0], 1'b0};
			tsc_pkg::FUNC_SHR: return {1'b0, a[15:1]};
			default:           return a;
		endcase
	endfunction

	task automatic new_program();
		foreach (used[i]) used[i] = 1'b0;
		emit_at = 0;
	endtask

	task automatic emit(tsc_pkg::word_t w);
		image[emit_at] = w;
		used[emit_at]  = 1'b1;
		emit_at++;
	endtask

	task automatic poke_data(int addr, tsc_pkg::word_t w);
		image[addr] = w;
		used[addr]  = 1'b1;
	endtask

	// LHI then ORI builds any word.
	task automatic set_reg(int r, tsc_pkg::word_t value);
		emit(imm_word(tsc_pkg::OP_LHI, 0, r, value[15:8]));
		emit(imm_word(tsc_pkg::OP_ORI, r, r, value[7:0]));
	endtask

	task automatic load_program();
		int a;
		@(posedge clk);
		for (a = 0; a < tsc_pkg::MEM_DEPTH; a++) begin
			if (used[a]) begin
				load       <= '{addr: tsc_pkg::mem_addr_t'(a), data: image[a]};
				load_valid <= 1'b1;
				@(posedge clk);
				while (!load_ready) @(posedge clk); // Beat moves on this edge.
				mmem[a] = image[a];
			end
		end
		load_valid <= 1'b0;
	endtask

	// Instruction-level model from PC zero to HLT.
	task automatic predict_outputs();
		tsc_pkg::word_t pc;
		tsc_pkg::word_t ins;
		tsc_pkg::word_t a;
		tsc_pkg::word_t b;
		tsc_pkg::word_t sx;
		tsc_pkg::word_t zx;
		tsc_pkg::word_t ea;
		int steps;
		bit done;
		model_q.delete();
		pc   = '0;
		done = 1'b0;
		for (steps = 0; steps < STEP_LIMIT && !done; steps++) begin
			ins = mmem[pc[7:0]];
			a   = mregs[ins[11:10]];
			b   = mregs[ins[9:8]];
			sx  = {{8{ins[7]}}, ins[7:0]};
			zx  = {8'h00, ins[7:0]};
			pc  = pc + 16'd1; // Targets are relative to the next word.
			ea  = a + sx;
			case (tsc_pkg::opcode_e'(ins[15:12]))
				tsc_pkg::OP_ALU: mregs[ins[7:6]] = func_ref(ins[5:0], a, b);
				tsc_pkg::OP_ADI: mregs[ins[9:8]] = a + sx;
				tsc_pkg::OP_ORI: mregs[ins[9:8]] = a | zx;
				tsc_pkg::OP_LHI: mregs[ins[9:8]] = {ins[7:0], 8'h00};
				tsc_pkg::OP_LWD: mregs[ins[9:8]] = mmem[ea[7:0]];
				tsc_pkg::OP_SWD: mmem[ea[7:0]] = b;
				tsc_pkg::OP_BNE: if (a != b) pc = pc + sx;
				tsc_pkg::OP_BEQ: if (a == b) pc = pc + sx;
				tsc_pkg::OP_BGZ: if (!a[15] && a != 16'd0) pc = pc + sx;
				tsc_pkg::OP_BLZ: if (a[15]) pc = pc + sx;
				tsc_pkg::OP_JMP: pc = {pc[15:12], ins[11:0]};
				tsc_pkg::OP_JAL: begin
					mregs[2] = pc; // Link register.
					pc       = {pc[15:12], ins[11:0]};
				end
				tsc_pkg::OP_JPR: pc = a;
				tsc_pkg::OP_WWD: model_q.push_back(a);
				tsc_pkg::OP_HLT: done = 1'b1;
				default: begin
					$display("reference model fetched unknown opcode %h", ins[15:12]);
					error_count++;
					done = 1'b1;
				end
			endcase
		end
		if (!done) begin
			$display("reference model ran %0d instructions without reaching HLT", STEP_LIMIT);
			error_count++;
		end
	endtask

	// Pulse start and wait for halted with a limit.
	task automatic run_program(output bit finished);
		int cycles;
		got_q.delete();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start    <= 1'b0;
		cycles   = 0;
		finished = 1'b0;
		while (!finished && cycles < RUN_LIMIT) begin
			@(posedge clk);
			cycles++;
			if (halted) finished = 1'b1;
		end
	endtask

	task automatic check_program(string name);
		bit finished;
		int errs;
		int i;
		errs = 0;
		load_program();
		predict_outputs();
		if (hand_q.size() != 0) exp_q = hand_q;
		else                    exp_q = model_q;
		run_program(finished);
		if (!finished) begin
			$display("%0t: %s did not raise halted within %0d cycles", $time, name, RUN_LIMIT);
			errs++;
		end
		if (!load_ready) begin
			$display("%0t: %s left load_ready low after the run", $time, name);
			errs++;
		end
		if (got_q.size() != exp_q.size()) begin
			$display("%0t: %s gave %0d output words where %0d were expected", $time, name,
				got_q.size(), exp_q.size());
			errs++;
		end
		for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
			if (got_q[i] !== exp_q[i]) begin
				$display("error t=%0t out_data[%0d] got %h expected %h", $time, i, got_q[i],
					exp_q[i]);
				errs++;
			end
		end
		$display("test %s %0d words, %0d errors", name, got_q.size(), errs);
		tests_run++;
		if (errs != 0) tests_failed++;
		error_count += errs;
		hand_q.delete();
	endtask

	task automatic reset_state();
		int errs;
		errs = 0;
		if (out_valid !== 1'b0) begin
			$display("error t=%0t out_valid got %b expected 0", $time, out_valid);
			errs++;
		end
		if (halted !== 1'b0) begin
			$display("error t=%0t halted got %b expected 0", $time, halted);
			errs++;
		end
		if (load_ready !== 1'b1) begin
			$display("error t=%0t load_ready got %b expected 1", $time, load_ready);
			errs++;
		end
		$display("test %s %0d errors", "reset", errs);
		tests_run++;
		if (errs != 0) tests_failed++;
		error_count += errs;
	endtask

	task automatic rtype_functions();
		int f;
		new_program();
		for (f = 0; f < 8; f++) begin
			set_reg(0, 16'($urandom) | 16'h8000); // Sign bit set so SHR shows its zero fill.
			set_reg(1, 16'($urandom));
			emit(rtype_word(0, 1, 3 - (f % 2), tsc_pkg::func_e'(f))); // rd alternates r3 and r2.
			emit(imm_word(tsc_pkg::OP_WWD, 3 - (f % 2), 0, 0));
		end
		emit(jump_word(tsc_pkg::OP_HLT, 0));
		check_program("rtype");
	endtask

	task automatic immediate_forms();
		new_program();
		emit(imm_word(tsc_pkg::OP_LHI, 0, 0, 8'h00));  // r0 = 0.
		emit(imm_word(tsc_pkg::OP_ADI, 0, 1, -3));     // Negative immediate.
		emit(imm_word(tsc_pkg::OP_WWD, 1, 0, 0));
		emit(imm_word(tsc_pkg::OP_ADI, 1, 1, 8'h7F));
		emit(imm_word(tsc_pkg::OP_WWD, 1, 0, 0));
		emit(imm_word(tsc_pkg::OP_LHI, 0, 2, 8'hA5));
		emit(imm_word(tsc_pkg::OP_WWD, 2, 0, 0));
		emit(imm_word(tsc_pkg::OP_ORI, 2, 2, 8'h5A));
		emit(imm_word(tsc_pkg::OP_WWD, 2, 0, 0));
		emit(imm_word(tsc_pkg::OP_ORI, 0, 3, 8'h80));  // ORI zero-extends.
		emit(imm_word(tsc_pkg::OP_WWD, 3, 0, 0));
		emit(imm_word(tsc_pkg::OP_ADI, 3, 3, 8'h80));  // 0x80 plus -128.
		emit(imm_word(tsc_pkg::OP_WWD, 3, 0, 0));
		emit(imm_word(tsc_pkg::OP_LHI, 0, 3, 8'hFF));
		emit(imm_word(tsc_pkg::OP_ADI, 3, 3, 8'hFF));
		emit(imm_word(tsc_pkg::OP_WWD, 3, 0, 0));
		emit(jump_word(tsc_pkg::OP_HLT, 0));
		hand_q = '{16'hFFFD, 16'h007C, 16'hA500, 16'hA55A, 16'h0080, 16'h0000, 16'hFEFF};
		check_program("immediate");
	endtask

	task automatic memory_access();
		int offs [3] = '{0, 7, -16}; // Base 0xC0 gives 0xC0, 0xC7, 0xB0.
		int i;
		new_program();
		for (i = 0; i < 4; i++) poke_data(8'hE0 + i, 16'($urandom));
		set_reg(0, 16'h00C0);
		for (i = 0; i < 4; i++) begin
			emit(imm_word(tsc_pkg::OP_LWD, 0, 1, 8'h20 + i)); // Words from the load port.
			emit(imm_word(tsc_pkg::OP_WWD, 1, 0, 0));
		end
		for (i = 0; i < 3; i++) begin
			set_reg(2, 16'($urandom));
			emit(imm_word(tsc_pkg::OP_SWD, 0, 2, offs[i]));
		end
		for (i = 2; i >= 0; i--) begin
			emit(imm_word(tsc_pkg::OP_LWD, 0, 3, offs[i])); // Reverse order.
			emit(imm_word(tsc_pkg::OP_WWD, 3, 0, 0));
		end
		emit(jump_word(tsc_pkg::OP_HLT, 0));
		check_program("memory");
	endtask

	task automatic branch_paths();
		tsc_pkg::opcode_e bop [8] = '{tsc_pkg::OP_BNE, tsc_pkg::OP_BEQ, tsc_pkg::OP_BNE,
			tsc_pkg::OP_BEQ, tsc_pkg::OP_BGZ, tsc_pkg::OP_BGZ, tsc_pkg::OP_BLZ, tsc_pkg::OP_BLZ};
		int brs [8] = '{0, 0, 0, 0, 0, 2, 2, 0};
		int brt [8] = '{1, 1, 2, 2, 0, 0, 0, 0};
		tsc_pkg::word_t pos;
		int k;
		new_program();
		pos = {1'b0, 15'($urandom)} | 16'h0100; // Positive and never zero.
		set_reg(0, pos);
		set_reg(1, pos);                           // Equal to r0.
		set_reg(2, {1'b1, 15'($urandom)});         // Negative.
		set_reg(3, 16'h0009);                      // Marker after each branch.
		for (k = 0; k < 8; k++) begin
			emit(imm_word(bop[k], brs[k], brt[k], 1)); // Taken skips the r0 word.
			emit(imm_word(tsc_pkg::OP_WWD, 0, 0, 0));
			emit(imm_word(tsc_pkg::OP_WWD, 3, 0, 0));
		end
		set_reg(1, 16'h0003);
		emit(imm_word(tsc_pkg::OP_ADI, 1, 1, -1));  // Backward loop counting 2 1 0.
		emit(imm_word(tsc_pkg::OP_WWD, 1, 0, 0));
		emit(imm_word(tsc_pkg::OP_BGZ, 1, 0, -3));
		emit(jump_word(tsc_pkg::OP_HLT, 0));
		check_program("branch");
	endtask

	task automatic jump_and_link();
		new_program();
		set_reg(0, 16'h0011);
		emit(jump_word(tsc_pkg::OP_JMP, 4));
		emit(imm_word(tsc_pkg::OP_WWD, 0, 0, 0));   // Skipped.
		set_reg(1, 16'h0022);
		emit(imm_word(tsc_pkg::OP_WWD, 1, 0, 0));
		emit(jump_word(tsc_pkg::OP_JAL, 20));       // Address 7 links 8.
		emit(imm_word(tsc_pkg::OP_WWD, 2, 0, 0));
		emit(jump_word(tsc_pkg::OP_JMP, 12));
		emit(imm_word(tsc_pkg::OP_WWD, 0, 0, 0));   // Skipped.
		emit(imm_word(tsc_pkg::OP_WWD, 1, 0, 0));   // Skipped.
		emit(jump_word(tsc_pkg::OP_HLT, 0));
		emit_at = 20; // Subroutine.
		emit(imm_word(tsc_pkg::OP_WWD, 2, 0, 0));
		emit(imm_word(tsc_pkg::OP_ORI, 0, 3, 8'h44));
		emit(imm_word(tsc_pkg::OP_WWD, 3, 0, 0));
		emit(imm_word(tsc_pkg::OP_JPR, 2, 0, 0));
		hand_q = '{16'h0022, 16'h0008, 16'h0055, 16'h0008};
		check_program("jump");
	endtask

	task automatic output_backpressure();
		new_program();
		set_reg(0, 16'($urandom));
		set_reg(1, 16'h0006);
		emit(imm_word(tsc_pkg::OP_WWD, 1, 0, 0));   // Loop body runs six passes.
		emit(imm_word(tsc_pkg::OP_WWD, 0, 0, 0));
		emit(imm_word(tsc_pkg::OP_ADI, 1, 1, -1));
		emit(imm_word(tsc_pkg::OP_BGZ, 1, 0, -4));
		set_reg(2, 16'($urandom));
		emit(imm_word(tsc_pkg::OP_WWD, 2, 0, 0));
		emit(imm_word(tsc_pkg::OP_WWD, 2, 0, 0));   // Same word twice in a row.
		emit(jump_word(tsc_pkg::OP_HLT, 0));
		bp_enable = 1'b1;
		check_program("backpressure");
		bp_enable = 1'b0;
	endtask

	initial begin
		void'($urandom(96));
		rst_n        = 1'b0;
		start        = 1'b0;
		load         = '0;
		load_valid   = 1'b0;
		bp_enable    = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		error_count  = 0;
		foreach (mregs[r]) mregs[r] = '0; // Reset clears the registers.
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		reset_state();
		rtype_functions();
		immediate_forms();
		memory_access();
		branch_paths();
		jump_and_link();
		output_backpressure();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tsc_top.sv
`default_nettype none

module tsc_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           start,
	input  tsc_pkg::load_t load,
	input  logic           load_valid,
	output logic           load_ready,
	output tsc_pkg::word_t out_data,
	output logic           out_valid,
	input  logic           out_ready,
	output logic           halted
);

	tsc_pkg::mem_req_t mem_req;
	tsc_pkg::word_t    mem_rdata;
	logic              core_idle; // IDLE or HALT.
	logic              load_en;

	assign load_ready = core_idle;               // Loads only while stopped.
	assign load_en    = core_idle & load_valid;  // Beat accepted.

	cpu_core cpu_core_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.halted    (halted),
		.idle      (core_idle)
	);

	unified_memory unified_memory_inst (
		.clk     (clk),
		.req     (mem_req),
		.rdata   (mem_rdata),
		.load    (load),
		.load_en (load_en)
	);

endmodule

`default_nettype wire

//--- unified_memory.sv
`default_nettype none

module unified_memory (
	input  logic              clk,
	input  tsc_pkg::mem_req_t req,
	output tsc_pkg::word_t    rdata,
	input  tsc_pkg::load_t    load,
	input  logic              load_en
);

	tsc_pkg::word_t mem [tsc_pkg::MEM_DEPTH]; // Instructions and data.

	// Load port wins over the core.
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load.addr] <= load.data;
		end else if (req.we) begin
			mem[req.addr] <= req.wdata;
		end
	end

	// Registered read. Valid one cycle after the address.
	always_ff @(posedge clk) begin
		rdata <= mem[req.addr];
	end

endmodule

`default_nettype wire

//--- cpu_core.sv
`default_nettype none

module cpu_core (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	output tsc_pkg::mem_req_t mem_req,
	input  tsc_pkg::word_t    mem_rdata,
	output tsc_pkg::word_t    out_data,
	output logic              out_valid,
	input  logic              out_ready,
	output logic              halted,
	output logic              idle
);

	tsc_pkg::word_t      pc;
	tsc_pkg::word_t      ir;      // Instruction register.
	tsc_pkg::word_t      a_reg;   // rs operand.
	tsc_pkg::word_t      b_reg;   // rt operand.
	tsc_pkg::word_t      res_reg; // ALU result or link address.
	tsc_pkg::word_t      rs_data;
	tsc_pkg::word_t      rt_data;
	tsc_pkg::word_t      alu_b;
	tsc_pkg::word_t      alu_result;
	tsc_pkg::word_t      pc_plus1;
	tsc_pkg::word_t      pc_next;
	tsc_pkg::word_t      wr_data;
	tsc_pkg::word_t      imm_sext;
	tsc_pkg::word_t      imm_zext;
	tsc_pkg::imm_t       imm;
	tsc_pkg::target_t    target;
	tsc_pkg::cpu_state_e state;
	tsc_pkg::alu_ctrl_t  alu_ctrl;
	tsc_pkg::reg_idx_t   wr_sel;
	logic                reg_wr;
	logic                mem_we;
	logic                ir_load;
	logic                cond;
	logic [1:0]          pc_src;

	assign imm      = ir[7:0];
	assign target   = ir[11:0];
	assign imm_sext = {{8{imm[7]}}, imm};
	assign imm_zext = {8'h00, imm};
	assign pc_plus1 = pc + 16'd1;

	control_unit control_unit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.instr     (ir),
		.cond      (cond),
		.out_ready (out_ready),
		.state     (state),
		.alu_ctrl  (alu_ctrl),
		.reg_wr    (reg_wr),
		.wr_sel    (wr_sel),
		.mem_we    (mem_we),
		.pc_src    (pc_src),
		.ir_load   (ir_load)
	);

	// Indices come straight from the fetched word during DECODE.
	register_file register_file_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_idx  (mem_rdata[11:10]),
		.rt_idx  (mem_rdata[9:8]),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_en   (reg_wr),
		.wr_idx  (wr_sel),
		.wr_data (wr_data)
	);

	// Second operand select.
	always_comb begin
		case (alu_ctrl.op)
			tsc_pkg::OP_ADI,
			tsc_pkg::OP_LWD,
			tsc_pkg::OP_SWD: alu_b = imm_sext;
			tsc_pkg::OP_ORI,
			tsc_pkg::OP_LHI: alu_b = imm_zext;
			default:         alu_b = b_reg;
		endcase
	end

	alu alu_inst (
		.a      (a_reg),
		.b      (alu_b),
		.ctrl   (alu_ctrl),
		.result (alu_result),
		.cond   (cond)
	);

	always_comb begin
		case (pc_src)
			tsc_pkg::PC_BRANCH: pc_next = pc_plus1 + imm_sext;
			tsc_pkg::PC_JUMP:   pc_next = {pc_plus1[15:12], target};
			tsc_pkg::PC_REG:    pc_next = a_reg;
			default:            pc_next = pc_plus1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if ((state == tsc_pkg::ST_IDLE || state == tsc_pkg::ST_HALT) && start) begin
			pc <= '0;
		end else if (state == tsc_pkg::ST_EXECUTE) begin
			pc <= pc_next; // One PC update per instruction.
		end
	end

	// Instruction and operand latches.
	always_ff @(posedge clk) begin
		if (ir_load) begin
			ir    <= mem_rdata;
			a_reg <= rs_data;
			b_reg <= rt_data;
		end
		if (state == tsc_pkg::ST_EXECUTE) begin
			res_reg <= (alu_ctrl.op == tsc_pkg::OP_JAL) ? pc_plus1 : alu_result;
		end
	end

	assign wr_data = (alu_ctrl.op == tsc_pkg::OP_LWD) ? mem_rdata : res_reg;

	// Data address in MEMORY, PC otherwise.
	assign mem_req.addr  = (state == tsc_pkg::ST_MEMORY) ?
		res_reg[$bits(tsc_pkg::mem_addr_t)-1:0] : pc[$bits(tsc_pkg::mem_addr_t)-1:0];
	assign mem_req.wdata = b_reg; // SWD stores rt.
	assign mem_req.we    = mem_we;

	assign out_data  = a_reg; // Stable through OUTPUT.
	assign out_valid = (state == tsc_pkg::ST_OUTPUT);
	assign halted    = (state == tsc_pkg::ST_HALT);
	assign idle      = (state == tsc_pkg::ST_IDLE) || halted;

endmodule

`default_nettype wire

//--- control_unit.sv
`default_nettype none

module control_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  tsc_pkg::word_t      instr,     // Instruction register.
	input  logic                cond,      // From the ALU.
	input  logic                out_ready,
	output tsc_pkg::cpu_state_e state,
	output tsc_pkg::alu_ctrl_t  alu_ctrl,
	output logic                reg_wr,
	output tsc_pkg::reg_idx_t   wr_sel,
	output logic                mem_we,
	output logic [1:0]          pc_src,
	output logic                ir_load
);

	tsc_pkg::opcode_e    op;
	tsc_pkg::func_e      func;
	tsc_pkg::cpu_state_e next_state;

	// Instruction fields.
	assign op   = tsc_pkg::opcode_e'(instr[15:12]);
	assign func = tsc_pkg::func_e'(instr[5:0]);

	assign alu_ctrl.op   = op;
	assign alu_ctrl.func = func;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= tsc_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Next state.
	always_comb begin
		next_state = state;
		case (state)
			tsc_pkg::ST_IDLE,
			tsc_pkg::ST_HALT: begin
				if (start) next_state = tsc_pkg::ST_FETCH; // Restart at PC zero.
			end
			tsc_pkg::ST_FETCH:  next_state = tsc_pkg::ST_DECODE; // Read in flight.
			tsc_pkg::ST_DECODE: next_state = tsc_pkg::ST_EXECUTE;
			tsc_pkg::ST_EXECUTE: begin
				case (op)
					tsc_pkg::OP_ALU,
					tsc_pkg::OP_ADI,
					tsc_pkg::OP_ORI,
					tsc_pkg::OP_LHI,
					tsc_pkg::OP_JAL: next_state = tsc_pkg::ST_WRITEBACK;
					tsc_pkg::OP_LWD,
					tsc_pkg::OP_SWD: next_state = tsc_pkg::ST_MEMORY;
					tsc_pkg::OP_WWD: next_state = tsc_pkg::ST_OUTPUT;
					tsc_pkg::OP_HLT: next_state = tsc_pkg::ST_HALT;
					default:         next_state = tsc_pkg::ST_FETCH; // Branches, jumps.
				endcase
			end
			tsc_pkg::ST_MEMORY: begin
				// Loads still need the register write.
				if (op == tsc_pkg::OP_LWD) next_state = tsc_pkg::ST_WRITEBACK;
				else                       next_state = tsc_pkg::ST_FETCH;
			end
			tsc_pkg::ST_WRITEBACK: next_state = tsc_pkg::ST_FETCH;
			tsc_pkg::ST_OUTPUT: begin
				if (out_ready) next_state = tsc_pkg::ST_FETCH; // Stall until taken.
			end
			default: next_state = tsc_pkg::ST_IDLE;
		endcase
	end

	// State-qualified strobes.
	assign ir_load = (state == tsc_pkg::ST_DECODE);
	assign reg_wr  = (state == tsc_pkg::ST_WRITEBACK);
	assign mem_we  = (state == tsc_pkg::ST_MEMORY) && (op == tsc_pkg::OP_SWD);

	// Destination register.
	always_comb begin
		case (op)
			tsc_pkg::OP_ALU: wr_sel = instr[7:6];        // rd.
			tsc_pkg::OP_JAL: wr_sel = tsc_pkg::LINK_REG;
			default:         wr_sel = instr[9:8];        // rt.
		endcase
	end

	// Next PC source, used by the core in EXECUTE.
	always_comb begin
		case (op)
			tsc_pkg::OP_BNE,
			tsc_pkg::OP_BEQ,
			tsc_pkg::OP_BGZ,
			tsc_pkg::OP_BLZ: pc_src = cond ? tsc_pkg::PC_BRANCH : tsc_pkg::PC_NEXT;
			tsc_pkg::OP_JMP,
			tsc_pkg::OP_JAL: pc_src = tsc_pkg::PC_JUMP;
			tsc_pkg::OP_JPR: pc_src = tsc_pkg::PC_REG;
			default:         pc_src = tsc_pkg::PC_NEXT;
		endcase
	end

endmodule

`default_nettype wire

//--- register_file.sv
`default_nettype none

module register_file (
	input  logic              clk,
	input  logic              rst_n,
	input  tsc_pkg::reg_idx_t rs_idx,
	input  tsc_pkg::reg_idx_t rt_idx,
	output tsc_pkg::word_t    rs_data,
	output tsc_pkg::word_t    rt_data,
	input  logic              wr_en,
	input  tsc_pkg::reg_idx_t wr_idx,
	input  tsc_pkg::word_t    wr_data
);

	tsc_pkg::word_t regs [tsc_pkg::NUM_REGS]; // Register array.

	// Single write port on the edge.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < tsc_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Two asynchronous read ports.
	assign rs_data = regs[rs_idx];
	assign rt_data = regs[rt_idx];

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
	input  tsc_pkg::word_t     a,      // Usually rs.
	input  tsc_pkg::word_t     b,      // rt or extended immediate.
	input  tsc_pkg::alu_ctrl_t ctrl,
	output tsc_pkg::word_t     result,
	output logic               cond    // Branch taken.
);

	// Word result.
	always_comb begin
		result = a; // Pass a through when nothing applies.
		case (ctrl.op)
			tsc_pkg::OP_ALU: begin
				case (ctrl.func)
					tsc_pkg::FUNC_ADD: result = a + b;
					tsc_pkg::FUNC_SUB: result = a - b;
					tsc_pkg::FUNC_AND: result = a & b;
					tsc_pkg::FUNC_ORR: result = a | b;
					tsc_pkg::FUNC_NOT: result = ~a;
					tsc_pkg::FUNC_TCP: result = (~a) + 16'd1; // Negate.
					tsc_pkg::FUNC_SHL: result = a << 1;
					tsc_pkg::FUNC_SHR: result = a >> 1;       // Zero fill.
					default:           result = a;
				endcase
			end
			// Immediate add and memory address.
			tsc_pkg::OP_ADI,
			tsc_pkg::OP_LWD,
			tsc_pkg::OP_SWD: result = a + b;
			tsc_pkg::OP_ORI: result = a | b;  // b is zero-extended.
			tsc_pkg::OP_LHI: result = b << 8; // Immediate to upper byte.
			default:         result = a;
		endcase
	end

	// Branch condition.
	always_comb begin
		cond = 1'b0;
		case (ctrl.op)
			tsc_pkg::OP_BNE: cond = (a != b);
			tsc_pkg::OP_BEQ: cond = (a == b);
			tsc_pkg::OP_BGZ: cond = ($signed(a) > 0);
			tsc_pkg::OP_BLZ: cond = ($signed(a) < 0);
			default:         cond = 1'b0; // Not a branch.
		endcase
	end

endmodule

`default_nettype wire

//--- tsc_pkg.sv
`default_nettype none

package tsc_pkg;

	// Core sizes.
	localparam int WORD_W    = 16;  // Data and instruction width.
	localparam int NUM_REGS  = 4;   // Architectural registers.
	localparam int MEM_DEPTH = 256; // Unified memory words.

	typedef logic [WORD_W-1:0]            word_t;
	typedef logic [$clog2(NUM_REGS)-1:0]  reg_idx_t;
	typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;
	typedef logic [7:0]                   imm_t;    // Instruction bits 7..0.
	typedef logic [11:0]                  target_t; // Instruction bits 11..0.

	localparam reg_idx_t LINK_REG = 2'd2; // JAL writes its return address here.

	// Next PC select.
	localparam logic [1:0] PC_NEXT   = 2'd0; // PC plus one.
	localparam logic [1:0] PC_BRANCH = 2'd1; // PC plus one plus offset.
	localparam logic [1:0] PC_JUMP   = 2'd2; // Low 12 bits from target.
	localparam logic [1:0] PC_REG    = 2'd3; // Register value.

	// Opcodes in bits 15..12.
	typedef enum logic [3:0] {
		OP_BNE = 4'd0,
		OP_BEQ = 4'd1,
		OP_BGZ = 4'd2,
		OP_BLZ = 4'd3,
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_JMP = 4'd9,
		OP_JAL = 4'd10,
		OP_JPR = 4'd11,
		OP_WWD = 4'd12,
		OP_HLT = 4'd13,
		OP_ALU = 4'd15  // R-type, function in bits 5..0.
	} opcode_e;

	// R-type functions.
	typedef enum logic [5:0] {
		FUNC_ADD = 6'd0,
		FUNC_SUB = 6'd1,
		FUNC_AND = 6'd2,
		FUNC_ORR = 6'd3,
		FUNC_NOT = 6'd4,
		FUNC_TCP = 6'd5, // Two's complement.
		FUNC_SHL = 6'd6,
		FUNC_SHR = 6'd7  // Logical shift.
	} func_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEMORY,
		ST_WRITEBACK,
		ST_OUTPUT,
		ST_HALT
	} cpu_state_e;

	typedef struct packed {
		opcode_e op;
		func_e   func;
	} alu_ctrl_t;

	typedef struct packed {
		mem_addr_t addr;
		word_t     wdata;
		logic      we;
	} mem_req_t;

	typedef struct packed {
		mem_addr_t addr;
		word_t     data;
	} load_t;

endpackage

`default_nettype wire
